/* analog_pkg.sv */
////////////////////////////////////////
// Sample and code types of the fast analog path
// Import into any block that handles ADC words,
// signed samples or DAC pin codes
////////////////////////////////////////

package analog_pkg;

  ////////////////////////////////////////
  // Widths

  localparam int NUM_CH    = 2;   // Analog channels on the board
  localparam int ADC_RAW_W = 16;  // ADC word incl. two reserved LSBs
  localparam int SAMPLE_W  = 14;  // Converter resolution

  ////////////////////////////////////////
  // Types

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;   // Raw ADC pins, negative slope
  typedef logic signed [SAMPLE_W-1:0]  sample_t;    // Two's complement sample
  typedef logic signed [SAMPLE_W:0]    dac_sum_t;   // One guard bit for the adder
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // DAC pins, negative slope offset

  // Pin code for sample zero
  // MSB clear, remaining bits set by the slope inversion
  localparam dac_code_t DAC_CODE_RESET = 14'h1FFF;

endpackage

/* io_pkg.sv */
////////////////////////////////////////
// Trigger, daisy link and expansion pin definitions
// Import into the trigger and pin routing blocks
////////////////////////////////////////

package io_pkg;

  // Daisy mode bits
  //   [0] synchronous trigger mode
  //   [1] trigger output on expansion n pin
  //   [2] generator trigger as trigger output, scope otherwise
  typedef logic [2:0] daisy_mode_t;

  // Parallel side of the daisy transceiver
  typedef logic [15:0] daisy_word_t;

  localparam daisy_word_t DAISY_IDLE_PATTERN = 16'h1234;  // Link test word

  ////////////////////////////////////////
  // Expansion connector positions

  localparam int unsigned TRIG_IN_PIN  = 0;  // p side, external trigger in
  localparam int unsigned TRIG_OUT_PIN = 0;  // n side, trigger out
  localparam int unsigned CAN0_PIN     = 7;
  localparam int unsigned CAN1_PIN     = 6;
  localparam int unsigned EXP_MIN_W    = 8;  // Highest fixed pin must fit

endpackage

/* adc_frontend.sv */
////////////////////////////////////////
// ADC input register for all channels
// Converts raw negative slope words to two's
// complement, or takes the DAC loopback sample
////////////////////////////////////////

`timescale 1ns/1ns

module adc_frontend
  import analog_pkg::*;
#(
  parameter int NUM_CH = analog_pkg::NUM_CH
) (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  adc_raw_t [NUM_CH-1:0] adc_dat_i,       // Raw converter words
  input  sample_t  [NUM_CH-1:0] loop_dat_i,      // Saturated DAC samples
  input  logic                  digital_loop_i,  // Loopback select level
  output sample_t  [NUM_CH-1:0] adc_dat_o
);

  sample_t [NUM_CH-1:0] conv_dat;  // Converted, before loop mux
  sample_t [NUM_CH-1:0] next_dat;

  // Two reserved LSBs dropped, sign kept, magnitude bits inverted
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_conv
    assign conv_dat[ch] = {adc_dat_i[ch][ADC_RAW_W-1],
                           ~adc_dat_i[ch][ADC_RAW_W-2:ADC_RAW_W-SAMPLE_W]};
    assign next_dat[ch] = digital_loop_i ? loop_dat_i[ch] : conv_dat[ch];
  end

  ////////////////////////////////////////
  // Sample register, one cycle latency

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_dat_o <= '0;        // Zero sample on every channel
    end else begin
      adc_dat_o <= next_dat;
    end
  end

endmodule

/* dac_backend.sv */
////////////////////////////////////////
// DAC output stage for all channels
// Adds generator and PID streams, clamps to the
// converter range and registers the pin code
////////////////////////////////////////

`timescale 1ns/1ns

module dac_backend
  import analog_pkg::*;
#(
  parameter int NUM_CH = analog_pkg::NUM_CH
) (
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  sample_t   [NUM_CH-1:0] asg_dat_i,     // Generator stream
  input  sample_t   [NUM_CH-1:0] pid_dat_i,     // Controller stream
  output sample_t   [NUM_CH-1:0] dac_sample_o,  // Clamped sum, same cycle
  output dac_code_t [NUM_CH-1:0] dac_dat_o      // Registered pin code
);

  dac_sum_t  [NUM_CH-1:0] sum_dat;   // Full precision sum
  logic      [NUM_CH-1:0] ovf;       // Sum outside 14-bit range
  sample_t   [NUM_CH-1:0] sat_dat;
  dac_code_t [NUM_CH-1:0] code_dat;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_sum
    // Both operands sign extended into the guard bit
    assign sum_dat[ch] = $signed(asg_dat_i[ch]) + $signed(pid_dat_i[ch]);

    // Guard and sign disagree on overflow
    assign ovf[ch] = sum_dat[ch][SAMPLE_W] ^ sum_dat[ch][SAMPLE_W-1];

    // Clamp to max positive or min negative, chosen by guard bit
    assign sat_dat[ch] = ovf[ch] ?
                         {sum_dat[ch][SAMPLE_W], {(SAMPLE_W-1){~sum_dat[ch][SAMPLE_W]}}} :
                         sum_dat[ch][SAMPLE_W-1:0];

    // Signed to offset code with negative slope
    assign code_dat[ch] = {sat_dat[ch][SAMPLE_W-1], ~sat_dat[ch][SAMPLE_W-2:0]};
  end

  assign dac_sample_o = sat_dat;  // Loopback source for the ADC side

  ////////////////////////////////////////
  // Pin code register

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_dat_o <= {NUM_CH{DAC_CODE_RESET}};  // Mid scale on all channels
    end else begin
      dac_dat_o <= code_dat;
    end
  end

endmodule

/* trigger_router.sv */
////////////////////////////////////////
// Trigger routing between expansion pin, daisy
// link, scope and generator
// Purely combinational, no clock
////////////////////////////////////////

`timescale 1ns/1ns

module trigger_router
  import io_pkg::*;
(
  input  logic        trig_pin_i,      // External trigger from expansion pin
  input  daisy_mode_t daisy_mode_i,
  input  logic        scope_trig_i,    // Scope trigger pulse
  input  logic        asg_trig_i,      // Generator trigger pulse
  input  daisy_word_t daisy_rx_dat_i,  // Word from the daisy receiver
  input  logic        daisy_rx_rdy_i,  // Receiver ready
  output logic        trig_ext_o,
  output logic        trig_out_o,
  output daisy_word_t daisy_tx_dat_o,
  output logic        daisy_tx_dv_o
);

  logic sync_mode;   // Mode bit 0
  logic daisy_trig;  // Any bit set in the received word

  assign sync_mode  = daisy_mode_i[0];
  assign daisy_trig = |daisy_rx_dat_i;

  ////////////////////////////////////////
  // Trigger selection

  // Pin trigger masked while the link carries one in sync mode
  assign trig_ext_o = trig_pin_i & ~(sync_mode & daisy_trig);

  assign trig_out_o = daisy_mode_i[2] ? asg_trig_i : scope_trig_i;  // Generator or scope

  ////////////////////////////////////////
  // Daisy transmit side

  always_comb begin
    if (sync_mode) begin
      daisy_tx_dat_o = {$bits(daisy_word_t){trig_out_o}};  // Trigger copied to every bit
      daisy_tx_dv_o  = 1'b0;                               // Raw word, no valid framing
    end else begin
      daisy_tx_dat_o = DAISY_IDLE_PATTERN;
      daisy_tx_dv_o  = daisy_rx_rdy_i;  // Send once the receiver has locked
    end
  end

endmodule

/* exp_pin_mux.sv */
////////////////////////////////////////
// Expansion connector alternate functions
// Overlays trigger out and CAN transmit on the n
// side and gates CAN receive from the p side
////////////////////////////////////////

`timescale 1ns/1ns

module exp_pin_mux
  import io_pkg::*;
#(
  parameter int unsigned EXP_W = 8
) (
  input  logic [EXP_W-1:0] exp_p_hk_dat_i,  // Housekeeping p data
  input  logic [EXP_W-1:0] exp_p_hk_oe_i,   // Housekeeping p enables
  input  logic [EXP_W-1:0] exp_n_hk_dat_i,
  input  logic [EXP_W-1:0] exp_n_hk_oe_i,
  input  logic [EXP_W-1:0] exp_p_pin_i,     // p pin read-back
  input  logic             can_on_i,        // CAN on the connector
  input  logic             can0_tx_i,
  input  logic             can1_tx_i,
  input  logic             trig_alt_i,      // Trigger out on the connector
  input  logic             trig_out_i,
  output logic [EXP_W-1:0] exp_p_dat_o,
  output logic [EXP_W-1:0] exp_p_oe_o,
  output logic [EXP_W-1:0] exp_n_dat_o,
  output logic [EXP_W-1:0] exp_n_oe_o,
  output logic             can0_rx_o,
  output logic             can1_rx_o
);

  // Fixed pin positions need the minimum connector width
  if (EXP_W < EXP_MIN_W) begin : g_width_check
    $error("exp_pin_mux: EXP_W smaller than EXP_MIN_W");
  end

  logic [EXP_W-1:0] n_alt;      // Pin owned by an alternate function
  logic [EXP_W-1:0] n_alt_dat;  // Value driven by that function

  ////////////////////////////////////////
  // Alternate function map, n side

  always_comb begin
    n_alt     = '0;
    n_alt_dat = '0;
    n_alt[TRIG_OUT_PIN]     = trig_alt_i;
    n_alt_dat[TRIG_OUT_PIN] = trig_out_i;
    n_alt[CAN0_PIN]         = can_on_i;
    n_alt_dat[CAN0_PIN]     = can0_tx_i;
    n_alt[CAN1_PIN]         = can_on_i;
    n_alt_dat[CAN1_PIN]     = can1_tx_i;
  end

  // Alternate functions always drive, housekeeping otherwise
  for (genvar i = 0; i < EXP_W; i++) begin : g_n_pin
    assign exp_n_dat_o[i] = n_alt[i] ? n_alt_dat[i] : exp_n_hk_dat_i[i];
    assign exp_n_oe_o[i]  = n_alt[i] ? 1'b1         : exp_n_hk_oe_i[i];
  end

  // No alternate functions on the p side
  assign exp_p_dat_o = exp_p_hk_dat_i;
  assign exp_p_oe_o  = exp_p_hk_oe_i;

  ////////////////////////////////////////
  // CAN receive

  assign can0_rx_o = can_on_i & exp_p_pin_i[CAN0_PIN];  // Idle low when CAN off
  assign can1_rx_o = can_on_i & exp_p_pin_i[CAN1_PIN];

endmodule

/* rp_analog_top.sv */
////////////////////////////////////////
// Board top level of the fast analog path
// ADC and DAC conversion, trigger routing and
// expansion pin muxing in the adc_clk domain
// Scope, generator, PID and housekeeping attach at the ports
////////////////////////////////////////

`timescale 1ns/1ns

module rp_analog_top
  import analog_pkg::*;
  import io_pkg::*;
#(
  parameter int unsigned EXP_W = 8
) (
  input  logic                   adc_clk,
  input  logic                   rst_i,

  // ADC
  input  adc_raw_t  [NUM_CH-1:0] adc_dat_i,       // Raw converter words
  output sample_t   [NUM_CH-1:0] adc_dat_o,       // To scope and PID

  // DAC
  input  sample_t   [NUM_CH-1:0] asg_dat_i,       // Generator stream
  input  sample_t   [NUM_CH-1:0] pid_dat_i,       // PID stream
  output dac_code_t [NUM_CH-1:0] dac_dat_o,       // One code per channel

  // Global configuration
  input  logic                   digital_loop_i,
  input  logic                   can_on_i,
  input  daisy_mode_t            daisy_mode_i,

  // Triggers
  input  logic                   scope_trig_i,
  input  logic                   asg_trig_i,
  output logic                   trig_ext_o,      // To scope and generator

  // Daisy link, parallel side
  input  daisy_word_t            daisy_rx_dat_i,
  input  logic                   daisy_rx_rdy_i,
  output daisy_word_t            daisy_tx_dat_o,
  output logic                   daisy_tx_dv_o,

  // CAN
  input  logic                   can0_tx_i,
  input  logic                   can1_tx_i,
  output logic                   can0_rx_o,
  output logic                   can1_rx_o,

  // Expansion connector
  input  logic [EXP_W-1:0]       exp_p_hk_dat_i,
  input  logic [EXP_W-1:0]       exp_p_hk_oe_i,
  input  logic [EXP_W-1:0]       exp_n_hk_dat_i,
  input  logic [EXP_W-1:0]       exp_n_hk_oe_i,
  input  logic [EXP_W-1:0]       exp_p_pin_i,     // Pin read-back
  output logic [EXP_W-1:0]       exp_p_dat_o,
  output logic [EXP_W-1:0]       exp_p_oe_o,
  output logic [EXP_W-1:0]       exp_n_dat_o,
  output logic [EXP_W-1:0]       exp_n_oe_o
);

  sample_t [NUM_CH-1:0] dac_sample;  // Clamped DAC sample for loopback
  logic                 trig_out;    // Selected trigger for the connector

  ////////////////////////////////////////
  // Analog path

  adc_frontend #(
    .NUM_CH         (NUM_CH)
  ) adc_frontend_inst (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_i      (adc_dat_i),
    .loop_dat_i     (dac_sample),
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_dat_o)
  );

  dac_backend #(
    .NUM_CH       (NUM_CH)
  ) dac_backend_inst (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .asg_dat_i    (asg_dat_i),
    .pid_dat_i    (pid_dat_i),
    .dac_sample_o (dac_sample),
    .dac_dat_o    (dac_dat_o)
  );

  ////////////////////////////////////////
  // Trigger and pin routing

  trigger_router trigger_router_inst (
    .trig_pin_i     (exp_p_pin_i[TRIG_IN_PIN]),  // External trigger input pin
    .daisy_mode_i   (daisy_mode_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out),
    .daisy_tx_dat_o (daisy_tx_dat_o),
    .daisy_tx_dv_o  (daisy_tx_dv_o)
  );

  exp_pin_mux #(
    .EXP_W          (EXP_W)
  ) exp_pin_mux_inst (
    .exp_p_hk_dat_i (exp_p_hk_dat_i),
    .exp_p_hk_oe_i  (exp_p_hk_oe_i),
    .exp_n_hk_dat_i (exp_n_hk_dat_i),
    .exp_n_hk_oe_i  (exp_n_hk_oe_i),
    .exp_p_pin_i    (exp_p_pin_i),
    .can_on_i       (can_on_i),
    .can0_tx_i      (can0_tx_i),
    .can1_tx_i      (can1_tx_i),
    .trig_alt_i     (daisy_mode_i[1]),  // Trigger out on connector
    .trig_out_i     (trig_out),
    .exp_p_dat_o    (exp_p_dat_o),
    .exp_p_oe_o     (exp_p_oe_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_n_oe_o     (exp_n_oe_o),
    .can0_rx_o      (can0_rx_o),
    .can1_rx_o      (can1_rx_o)
  );

endmodule

/* tb_model.svh */
////////////////////////////////////////
// Reference model of the analog top level
// Included in the testbench module body
////////////////////////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int          SAMPLE_MAX = (1 << (SAMPLE_W - 1)) - 1;
localparam int          SAMPLE_MIN = -(1 << (SAMPLE_W - 1));
localparam logic [13:0] SLOPE_MASK = 14'h1FFF;  // Bits flipped by the negative slope

sample_t   [NUM_CH-1:0] exp_adc;       // Expected registers one cycle behind
dac_code_t [NUM_CH-1:0] exp_dac;
logic                   exp_trig_ext;  // Expected combinational outputs
logic                   exp_trig_out;
daisy_word_t            exp_tx_dat;
logic                   exp_tx_dv;
logic      [EXP_W-1:0]  exp_n_dat;
logic      [EXP_W-1:0]  exp_n_oe;
logic                   exp_can0_rx;
logic                   exp_can1_rx;

// Integer sum limited to the converter range
function automatic sample_t clamp_sum(input sample_t a, input sample_t b);
  int s;
  s = int'(a) + int'(b);
  if (s > SAMPLE_MAX) s = SAMPLE_MAX;
  if (s < SAMPLE_MIN) s = SAMPLE_MIN;
  return sample_t'(s);
endfunction

////////////////////////////////////////
// Register stages updated at each rising edge

task automatic model_clock();
  for (int ch = 0; ch < NUM_CH; ch++) begin
    if (rst_i) begin
      exp_adc[ch] = '0;
      exp_dac[ch] = 14'h1FFF;  // Code of sample zero
    end else begin
      exp_adc[ch] = digital_loop_i ? clamp_sum(asg_dat_i[ch], pid_dat_i[ch])
                                   : sample_t'(adc_dat_i[ch][15:2] ^ SLOPE_MASK);
      exp_dac[ch] = clamp_sum(asg_dat_i[ch], pid_dat_i[ch]) ^ SLOPE_MASK;  // Offset code
    end
  end
endtask

////////////////////////////////////////
// Trigger and pin routing within the same cycle

task automatic model_route();
  logic daisy_trig;
  daisy_trig   = (daisy_rx_dat_i != '0);
  exp_trig_ext = exp_p_pin_i[TRIG_IN_PIN] && !(daisy_mode_i[0] && daisy_trig);
  exp_trig_out = daisy_mode_i[2] ? asg_trig_i : scope_trig_i;
  if (daisy_mode_i[0]) begin
    exp_tx_dat = exp_trig_out ? 16'hFFFF : 16'h0000;  // Trigger on every bit
    exp_tx_dv  = 1'b0;
  end else begin
    exp_tx_dat = 16'h1234;  // Idle link word
    exp_tx_dv  = daisy_rx_rdy_i;
  end
  exp_n_dat = exp_n_hk_dat_i;  // Housekeeping unless overridden
  exp_n_oe  = exp_n_hk_oe_i;
  if (daisy_mode_i[1]) begin
    exp_n_dat[TRIG_OUT_PIN] = exp_trig_out;
    exp_n_oe[TRIG_OUT_PIN]  = 1'b1;
  end
  if (can_on_i) begin
    exp_n_dat[CAN0_PIN] = can0_tx_i;
    exp_n_dat[CAN1_PIN] = can1_tx_i;
    exp_n_oe[CAN0_PIN]  = 1'b1;
    exp_n_oe[CAN1_PIN]  = 1'b1;
  end
  exp_can0_rx = can_on_i ? exp_p_pin_i[CAN0_PIN] : 1'b0;
  exp_can1_rx = can_on_i ? exp_p_pin_i[CAN1_PIN] : 1'b0;
endtask

`endif

/* tb_rp_analog_top.sv */
////////////////////////////////////////
// Testbench for the analog top level
// LFSR driven random stimulus, checked each cycle
// against the included reference model
////////////////////////////////////////

`timescale 1ns/1ns

module tb_rp_analog_top
  import analog_pkg::*;
  import io_pkg::*;
();

  localparam int unsigned EXP_W  = 8;
  localparam int RST_CYCLES      = 4;
  localparam int NUM_CYCLES      = 2000;
  localparam int MODE_PERIOD     = 64;                                  // Loop and mode changes
  localparam int TIMEOUT_CYCLES  = RST_CYCLES + NUM_CYCLES + 96;        // 2100

  logic                   adc_clk;
  logic                   rst_i;
  adc_raw_t  [NUM_CH-1:0] adc_dat_i;
  sample_t   [NUM_CH-1:0] adc_dat_o;
  sample_t   [NUM_CH-1:0] asg_dat_i;
  sample_t   [NUM_CH-1:0] pid_dat_i;
  dac_code_t [NUM_CH-1:0] dac_dat_o;
  logic                   digital_loop_i, can_on_i;
  daisy_mode_t            daisy_mode_i;
  logic                   scope_trig_i, asg_trig_i, trig_ext_o;
  daisy_word_t            daisy_rx_dat_i, daisy_tx_dat_o;
  logic                   daisy_rx_rdy_i, daisy_tx_dv_o;
  logic                   can0_tx_i, can1_tx_i, can0_rx_o, can1_rx_o;
  logic      [EXP_W-1:0]  exp_p_hk_dat_i, exp_p_hk_oe_i, exp_n_hk_dat_i, exp_n_hk_oe_i;
  logic      [EXP_W-1:0]  exp_p_pin_i;
  logic      [EXP_W-1:0]  exp_p_dat_o, exp_p_oe_o, exp_n_dat_o, exp_n_oe_o;

  logic [15:0] lfsr_state;
  int          cycle_cnt = 0;

  `include "tb_model.svh"

  rp_analog_top #(.EXP_W(EXP_W)) rp_analog_top_inst (.*);

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 ns period
  end

  ////////////////////////////////////////
  // Failure handling and compare tasks

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_dac_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_pins(input string name, input logic [EXP_W-1:0] got,
                            input logic [EXP_W-1:0] exp);
    if (got !== exp) abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_daisy_word(input string name, input daisy_word_t got,
                                  input daisy_word_t exp);
    if (got !== exp) abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_outputs();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_sample($sformatf("adc_dat_o[%0d]", ch), adc_dat_o[ch], exp_adc[ch]);
      check_dac_code($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], exp_dac[ch]);
    end
    check_bit("trig_ext_o", trig_ext_o, exp_trig_ext);
    check_daisy_word("daisy_tx_dat_o", daisy_tx_dat_o, exp_tx_dat);
    check_bit("daisy_tx_dv_o", daisy_tx_dv_o, exp_tx_dv);
    check_pins("exp_p_dat_o", exp_p_dat_o, exp_p_hk_dat_i);  // p side passes through
    check_pins("exp_p_oe_o", exp_p_oe_o, exp_p_hk_oe_i);
    check_pins("exp_n_dat_o", exp_n_dat_o, exp_n_dat);
    check_pins("exp_n_oe_o", exp_n_oe_o, exp_n_oe);
    check_bit("can0_rx_o", can0_rx_o, exp_can0_rx);
    check_bit("can1_rx_o", can1_rx_o, exp_can1_rx);
  endtask

  ////////////////////////////////////////
  // Random stimulus

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // Full scale half of the time so the clamp gets hit
  task automatic draw_sample(output sample_t val);
    logic [31:0] r;
    draw_bits(2, r);
    case (r[1:0])
      2'd0:    val = sample_t'(SAMPLE_MAX);
      2'd1:    val = sample_t'(SAMPLE_MIN);
      default: begin
        draw_bits(SAMPLE_W, r);
        val = r[SAMPLE_W-1:0];
      end
    endcase
  endtask

  task automatic drive_inputs(input bit new_mode);
    logic [31:0] r;
    sample_t     s;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      draw_bits(ADC_RAW_W, r);
      adc_dat_i[ch] = r[ADC_RAW_W-1:0];
      draw_sample(s);
      asg_dat_i[ch] = s;
      draw_sample(s);
      pid_dat_i[ch] = s;
    end
    draw_bits(6, r);
    scope_trig_i   = r[0];
    asg_trig_i     = r[1];
    daisy_rx_rdy_i = r[2];
    can0_tx_i      = r[3];
    can1_tx_i      = r[4];
    if (r[5]) begin
      daisy_rx_dat_i = '0;  // No daisy trigger
    end else begin
      draw_bits(16, r);
      daisy_rx_dat_i = r[15:0];
    end
    draw_bits(EXP_W, r);
    exp_p_hk_dat_i = r[EXP_W-1:0];
    draw_bits(EXP_W, r);
    exp_p_hk_oe_i = r[EXP_W-1:0];
    draw_bits(EXP_W, r);
    exp_n_hk_dat_i = r[EXP_W-1:0];
    draw_bits(EXP_W, r);
    exp_n_hk_oe_i = r[EXP_W-1:0];
    draw_bits(EXP_W, r);
    exp_p_pin_i = r[EXP_W-1:0];
    if (new_mode) begin
      draw_bits(5, r);
      digital_loop_i = r[0];
      can_on_i       = r[1];
      daisy_mode_i   = r[4:2];
    end
  endtask

  ////////////////////////////////////////
  // Cycle sequence

  task automatic run_cycle(input int cyc);
    @(posedge adc_clk);
    model_clock();                        // Inputs still those of the past cycle
    #2;
    rst_i = (cyc < RST_CYCLES - 1);       // High over the first 4 edges
    drive_inputs(cyc % MODE_PERIOD == 0);
    #1;
    model_route();
    check_outputs();
  endtask

  always @(posedge adc_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout, test still running after %0d cycles", cycle_cnt));
    end
  end

  initial begin
    lfsr_state     = 16'd51;
    rst_i          = 1'b1;
    adc_dat_i      = '0;
    asg_dat_i      = '0;
    pid_dat_i      = '0;
    digital_loop_i = 1'b0;
    can_on_i       = 1'b0;
    daisy_mode_i   = '0;
    scope_trig_i   = 1'b0;
    asg_trig_i     = 1'b0;
    daisy_rx_dat_i = '0;
    daisy_rx_rdy_i = 1'b0;
    can0_tx_i      = 1'b0;
    can1_tx_i      = 1'b0;
    exp_p_hk_dat_i = '0;
    exp_p_hk_oe_i  = '0;
    exp_n_hk_dat_i = '0;
    exp_n_hk_oe_i  = '0;
    exp_p_pin_i    = '0;
    for (int cyc = 0; cyc < RST_CYCLES + NUM_CYCLES; cyc++) begin
      run_cycle(cyc);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
analog_pkg.sv
io_pkg.sv
adc_frontend.sv
dac_backend.sv
trigger_router.sv
exp_pin_mux.sv
rp_analog_top.sv
tb_rp_analog_top.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it, the exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_rp_analog_top -f project.f -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation did not complete cleanly"; exit 1; }
